/* Makefile */
# Verilator build for the Hack core testbench
# any variable can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_hack_cpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits with a failing status on $fatal or a failed assertion
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_unit
    import hack_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          resetN,
    input  wire decoded_inst_t dec,
    input  wire logic          inst_valid,
    input  wire hack_word_t    in_m,
    output ram_addr_t          read_addr,
    output ram_wr_t            ram_wr,
    output pc_t                next_pc,
    output logic               pc_load
);

    decoded_inst_t dec_q;
    logic          exec_q;
    hack_word_t    a_q;
    hack_word_t    d_q;
    pc_t           pc_q;
    hack_word_t    alu_y;
    hack_word_t    alu_result;
    alu_flags_t    alu_flags;
    hack_word_t    a_nxt;
    logic          positive;
    logic          take_jump;

    // ************************************************************
    // D cycle
    // ************************************************************

    // the decoded instruction is held for the E cycle that follows
    always_ff @(posedge clk)
    begin
        if (inst_valid)
            dec_q <= dec;
    end

    // A only changes at the close of an E cycle
    // so during D it is the old A that addresses the M read
    assign read_addr = a_q[RAM_ADDR_W-1:0];

    // ************************************************************
    // E cycle
    // ************************************************************

    // M has arrived from the RAM by now and stands in for A when the a bit says so
    assign alu_y = dec_q.sel_m ? in_m : a_q;

    hack_alu alu_inst (
        .x      (d_q),
        .y      (alu_y),
        .fn     (dec_q.alu_fn),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // an A-instruction loads its immediate, a C-instruction the ALU result
    assign a_nxt = dec_q.is_c ? alu_result : {1'b0, dec_q.imm};

    // jump bits are cleared in decode for A-instructions, so they never jump
    assign positive  = !alu_flags.neg && !alu_flags.zero;
    assign take_jump = (dec_q.jump.jlt && alu_flags.neg) ||
                       (dec_q.jump.jeq && alu_flags.zero) ||
                       (dec_q.jump.jgt && positive);

    // the jump target is the A value from before this instruction
    assign next_pc = take_jump ? a_q[PC_W-1:0] : pc_q + pc_t'(1);
    assign pc_load = exec_q;

    // the M write also goes to the old A, even when A is a destination too
    always_comb
    begin
        ram_wr.en   = exec_q && dec_q.dest.load_m;
        ram_wr.addr = a_q[RAM_ADDR_W-1:0];
        ram_wr.data = alu_result;
    end

    // ************************************************************
    // architectural registers
    // ************************************************************

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            exec_q <= 1'b0;
            a_q    <= '0;
            d_q    <= '0;
            pc_q   <= '0;
        end
        else
        begin
            // one E cycle per decoded instruction
            exec_q <= inst_valid;
            if (exec_q)
            begin
                if (dec_q.dest.load_a)
                    a_q <= a_nxt;
                if (dec_q.dest.load_d)
                    d_q <= alu_result;
                pc_q <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* files.f */
hack_pkg.sv
hack_alu.sv
inst_fetch.sv
inst_decode.sv
exec_unit.sv
hack_cpu.sv
hack_cpu_props.sv
tb_hack_cpu.sv

/* hack_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module hack_alu
    import hack_pkg::*;
(
    input  wire hack_word_t          x,
    input  wire hack_word_t          y,
    input  wire logic [ALU_FN_W-1:0] fn,
    output hack_word_t               result,
    output alu_flags_t               flags
);

    logic       zx;
    logic       nx;
    logic       zy;
    logic       ny;
    logic       f_add;
    logic       no;
    hack_word_t x_z;
    hack_word_t x_n;
    hack_word_t y_z;
    hack_word_t y_n;
    hack_word_t f_out;

    // control bits in instruction order, zx is the msb of the field
    assign {zx, nx, zy, ny, f_add, no} = fn;

    // ************************************************************
    // operand conditioning, function, output negate
    // ************************************************************

    always_comb
    begin
        x_z = zx ? '0 : x;
        x_n = nx ? ~x_z : x_z;
        y_z = zy ? '0 : y;
        y_n = ny ? ~y_z : y_z;

        // the sum wraps at 16 bits like the reference machine
        f_out = f_add ? (x_n + y_n) : (x_n & y_n);

        result = no ? ~f_out : f_out;
    end

    // flags come from the final result, after the output negate
    assign flags.zero = (result == '0);
    assign flags.neg  = result[DATA_W-1];

endmodule

`default_nettype wire

/* hack_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module hack_cpu
    import hack_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetN,

    // instruction ROM, data one cycle after the address
    output rom_addr_t       inst_addr,
    input  wire rom_word_t  inst,

    // data RAM read port, data one cycle after the address
    output ram_addr_t       read_addr,
    input  wire hack_word_t in_m,

    // data RAM write port
    output ram_wr_t         ram_wr
);

    // fetch to decode
    hack_word_t    fetch_inst;
    logic          inst_valid;
    // decode to execute
    decoded_inst_t dec;
    // execute back to fetch
    pc_t           next_pc;
    logic          pc_load;

    // ************************************************************
    // fetch, decode, execute
    // ************************************************************

    inst_fetch fetch_inst_u (
        .clk        (clk),
        .resetN     (resetN),
        .next_pc    (next_pc),
        .pc_load    (pc_load),
        .inst_addr  (inst_addr),
        .rom_data   (inst),
        .inst       (fetch_inst),
        .inst_valid (inst_valid)
    );

    inst_decode decode_inst (
        .inst (fetch_inst),
        .dec  (dec)
    );

    exec_unit exec_inst (
        .clk        (clk),
        .resetN     (resetN),
        .dec        (dec),
        .inst_valid (inst_valid),
        .in_m       (in_m),
        .read_addr  (read_addr),
        .ram_wr     (ram_wr),
        .next_pc    (next_pc),
        .pc_load    (pc_load)
    );

endmodule

`default_nettype wire

/* hack_cpu_props.sv */
`timescale 1ns/100ps
`default_nettype none

module hack_cpu_props
(
    input wire logic clk,
    input wire logic resetN,
    input wire logic inst_valid,
    input wire logic pc_load,
    input wire logic ram_wr_en
);

    // ************************************************************
    // core timing
    // ************************************************************

    // the RAM must never see a write while the core is held in reset
    no_write_in_reset: assert property (@(posedge clk) !resetN |-> !ram_wr_en)
        else $error("RAM write enable high during reset");

    // a buffer hit answers one cycle after pc_load, a ROM read two cycles after it
    // so two cycles on, inst_valid is due unless it already came
    fetch_latency: assert property (@(posedge clk) disable iff (!resetN)
        ($past(pc_load, 2) && !$past(inst_valid)) |-> inst_valid)
        else $error("inst_valid did not follow pc_load within two cycles");

    // the E cycle always follows the D cycle
    exec_after_decode: assert property (@(posedge clk) disable iff (!resetN)
        inst_valid |=> pc_load)
        else $error("pc_load missing one cycle after inst_valid");

endmodule

bind hack_cpu hack_cpu_props props_inst (
    .clk        (clk),
    .resetN     (resetN),
    .inst_valid (inst_valid),
    .pc_load    (pc_load),
    .ram_wr_en  (ram_wr.en)
);

`default_nettype wire

/* hack_pkg.sv */
`default_nettype none

package hack_pkg;

    // ************************************************************
    // widths of the core's buses
    // ************************************************************

    // one data word and the ALU datapath
    localparam int DATA_W     = 16;
    // instruction address, one per 16-bit instruction
    localparam int PC_W       = 15;
    // two instructions share a ROM word, so the word address drops pc bit 0
    localparam int ROM_ADDR_W = PC_W - 1;
    localparam int RAM_ADDR_W = 15;
    // zx nx zy ny f no
    localparam int ALU_FN_W   = 6;

    // ************************************************************
    // bit positions inside one 16-bit instruction
    // ************************************************************

    // set for a C-instruction, clear for an A-instruction
    localparam int BIT_C      = 15;
    // the a bit picks M instead of A as the y operand
    localparam int BIT_AM     = 12;
    localparam int ALU_FN_LSB = 6;

    // destination field
    localparam int BIT_LD_A   = 5;
    localparam int BIT_LD_D   = 4;
    localparam int BIT_LD_M   = 3;

    // jump field, one bit per sign of the ALU result
    localparam int BIT_JLT    = 2;
    localparam int BIT_JEQ    = 1;
    localparam int BIT_JGT    = 0;

    // ************************************************************
    // types
    // ************************************************************

    typedef logic [DATA_W-1:0]     hack_word_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    // low half holds the even instruction, high half the odd one
    typedef logic [2*DATA_W-1:0]   rom_word_t;

    typedef struct packed {
        logic load_a;
        logic load_d;
        logic load_m;
    } dest_t;

    typedef struct packed {
        logic jlt;
        logic jeq;
        logic jgt;
    } jump_t;

    // one instruction after decode, with A-instruction forms already normalized
    typedef struct packed {
        logic                is_c;
        logic [DATA_W-2:0]   imm;
        logic                sel_m;
        logic [ALU_FN_W-1:0] alu_fn;
        dest_t               dest;
        jump_t               jump;
    } decoded_inst_t;

    // one M write, sampled by the RAM at the clock edge while en is high
    typedef struct packed {
        logic       en;
        ram_addr_t  addr;
        hack_word_t data;
    } ram_wr_t;

    typedef struct packed {
        logic zero;
        logic neg;
    } alu_flags_t;

endpackage

`default_nettype wire

/* inst_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decode
    import hack_pkg::*;
(
    input  wire hack_word_t inst,
    output decoded_inst_t   dec
);

    // ************************************************************
    // field split
    // ************************************************************

    // all instruction-type tests live here
    // execute only sees the normalized struct below
    always_comb
    begin
        dec = '0;

        dec.is_c = inst[BIT_C];

        // the immediate is only meaningful for an A-instruction
        // it is filled either way since execute ignores it for C
        dec.imm = inst[DATA_W-2:0];

        if (inst[BIT_C])
        begin
            // y operand from M when the a bit is set
            dec.sel_m  = inst[BIT_AM];
            dec.alu_fn = inst[ALU_FN_LSB +: ALU_FN_W];

            dec.dest.load_a = inst[BIT_LD_A];
            dec.dest.load_d = inst[BIT_LD_D];
            dec.dest.load_m = inst[BIT_LD_M];

            dec.jump.jlt = inst[BIT_JLT];
            dec.jump.jeq = inst[BIT_JEQ];
            dec.jump.jgt = inst[BIT_JGT];
        end
        else
        begin
            // an A-instruction only writes A
            // the low bits of the word are the value, not dest or jump flags
            dec.sel_m       = 1'b0;
            dec.alu_fn      = '0;
            dec.dest.load_a = 1'b1;
            dec.dest.load_d = 1'b0;
            dec.dest.load_m = 1'b0;

            // no jump can come from an A-instruction
            dec.jump = '0;
        end
    end

endmodule

`default_nettype wire

/* inst_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_fetch
    import hack_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       resetN,
    input  wire pc_t        next_pc,
    input  wire logic       pc_load,
    output rom_addr_t       inst_addr,
    input  wire rom_word_t  rom_data,
    output hack_word_t      inst,
    output logic            inst_valid
);

    // F_START acts as the implicit fetch of pc 0 right after reset release
    // F_ROM is the cycle in which the ROM answers a read issued one cycle earlier
    typedef enum logic [1:0] {
        F_START,
        F_IDLE,
        F_ROM,
        F_VALID
    } fetch_state_t;

    fetch_state_t state_q;
    fetch_state_t state_nxt;
    pc_t          pc_q;
    pc_t          req_pc;
    rom_addr_t    req_word;
    logic         req;
    logic         hit;
    rom_word_t    buf_word_q;
    rom_addr_t    buf_addr_q;
    logic         buf_valid_q;

    // ************************************************************
    // request and buffer lookup
    // ************************************************************

    // a request is either the first fetch after reset or a new pc from execute
    assign req      = (state_q == F_START) || ((state_q == F_IDLE) && pc_load);
    assign req_pc   = pc_load ? next_pc : pc_q;
    assign req_word = req_pc[PC_W-1:1];

    // the buffered word already holds both halves, so any pc inside it needs no read
    assign hit      = buf_valid_q && (buf_addr_q == req_word);

    // a miss presents the new word address in the request cycle itself
    // otherwise the bus just keeps the address of the buffered word
    assign inst_addr = (req && !hit) ? req_word : buf_addr_q;

    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            F_START, F_IDLE:
                if (req)
                    state_nxt = hit ? F_VALID : F_ROM;
            F_ROM:
                state_nxt = F_VALID;
            F_VALID:
                state_nxt = F_IDLE;
            default:
                state_nxt = F_IDLE;
        endcase
    end

    // ************************************************************
    // state, pc and word buffer
    // ************************************************************

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            state_q     <= F_START;
            pc_q        <= '0;
            buf_valid_q <= 1'b0;
        end
        else
        begin
            state_q <= state_nxt;
            if (req)
                pc_q <= req_pc;
            // the buffer becomes usable once the first ROM word lands
            if (state_q == F_ROM)
                buf_valid_q <= 1'b1;
        end
    end

    // the address tag moves at the request, the data one cycle later with the ROM answer
    // no lookup happens in between, so the short mismatch is never seen
    always_ff @(posedge clk)
    begin
        if (req && !hit)
            buf_addr_q <= req_word;
        if (state_q == F_ROM)
            buf_word_q <= rom_data;
    end

    // pc bit 0 selects the odd (high) or even (low) instruction of the word
    assign inst       = pc_q[0] ? buf_word_q[2*DATA_W-1:DATA_W] : buf_word_q[DATA_W-1:0];
    assign inst_valid = (state_q == F_VALID);

endmodule

`default_nettype wire

/* tb_hack_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_hack_cpu
    import hack_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int MAX_STEPS  = 4000;

    // ALU control codes in zx nx zy ny f no order, y is A or M
    localparam logic [ALU_FN_W-1:0] FN_ZERO   = 6'b101010;
    localparam logic [ALU_FN_W-1:0] FN_D      = 6'b001100;
    localparam logic [ALU_FN_W-1:0] FN_Y      = 6'b110000;
    localparam logic [ALU_FN_W-1:0] FN_NEG_D  = 6'b001111;
    localparam logic [ALU_FN_W-1:0] FN_Y_INC  = 6'b110111;
    localparam logic [ALU_FN_W-1:0] FN_Y_DEC  = 6'b110010;
    // destination field is A D M, jump field is lt eq gt
    localparam logic [2:0] DST_NONE = 3'b000;
    localparam logic [2:0] DST_M    = 3'b001;
    localparam logic [2:0] DST_D    = 3'b010;
    localparam logic [2:0] DST_AM   = 3'b101;
    localparam logic [2:0] DST_AMD  = 3'b111;
    localparam logic [2:0] JMP_NONE = 3'b000;
    localparam logic [2:0] JMP_ALL  = 3'b111;

    // the 18 functions of the Hack instruction set
    localparam logic [ALU_FN_W-1:0] ALU_CODES [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };
    // JLT JEQ JGT JMP and a C-instruction without any jump
    localparam logic [2:0] JUMP_CODES [5] = '{3'b100, 3'b010, 3'b001, 3'b111, 3'b000};

    logic       clk;
    logic       resetN;
    rom_addr_t  inst_addr;
    ram_addr_t  read_addr;
    ram_wr_t    ram_wr;
    rom_word_t  rom_q = '0;
    hack_word_t ram_q = '0;

    rom_word_t  rom     [0:(1 << ROM_ADDR_W)-1];
    hack_word_t ram     [0:(1 << RAM_ADDR_W)-1];
    hack_word_t ram_ref [0:(1 << RAM_ADDR_W)-1];

    // program as 16-bit instructions, with the name of the test each belongs to
    hack_word_t prog[$];
    string      prog_tag[$];
    ram_wr_t    exp_wr[$];
    string      exp_wr_tag[$];
    rom_addr_t  exp_rom[$];
    string      exp_rom_tag[$];
    // cycle after reset release in which each ROM read is due
    int         exp_rom_cyc[$];

    integer     seed;
    int         n_steps;
    int         halt_pc;
    int         cycle_count = 0;
    logic       ref_ready = 1'b0;
    logic       first_fetch = 1'b1;
    rom_addr_t  last_rom_addr;

    hack_cpu hack_cpu_inst (
        .clk       (clk),
        .resetN    (resetN),
        .inst_addr (inst_addr),
        .inst      (rom_q),
        .read_addr (read_addr),
        .in_m      (ram_q),
        .ram_wr    (ram_wr)
    );

    // ************************************************************
    // clock and memory models
    // ************************************************************

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // both memories answer one cycle after the address, the RAM writes at the edge
    always @(posedge clk)
    begin
        rom_q <= rom[inst_addr];
        ram_q <= ram[read_addr];
        if (ram_wr.en)
            ram[ram_wr.addr] <= ram_wr.data;
    end

    // ************************************************************
    // instruction encoding and reference model
    // ************************************************************

    function automatic hack_word_t a_instr(input logic [PC_W-1:0] value);
        return {1'b0, value};
    endfunction

    function automatic hack_word_t c_instr(input logic sel_m, input logic [ALU_FN_W-1:0] fn,
                                           input logic [2:0] dest, input logic [2:0] jump);
        return {3'b111, sel_m, fn, dest, jump};
    endfunction

    // every address bit changes the word, so a wrong RAM address shows up in the data
    function automatic hack_word_t ram_fill(input int unsigned addr);
        return hack_word_t'(addr * 32'd40503) ^ hack_word_t'(addr >> 7);
    endfunction

    // Hack function table by mnemonic, x is D and y is A or M
    function automatic hack_word_t expected_alu(input logic [ALU_FN_W-1:0] fn,
                                                input hack_word_t x, input hack_word_t y);
        case (fn)
            6'b101010: return '0;
            6'b111111: return 16'd1;
            6'b111010: return '1;
            6'b001100: return x;
            6'b110000: return y;
            6'b001101: return ~x;
            6'b110001: return ~y;
            6'b001111: return -x;
            6'b110011: return -y;
            6'b011111: return x + 16'd1;
            6'b110111: return y + 16'd1;
            6'b001110: return x - 16'd1;
            6'b110010: return y - 16'd1;
            6'b000010: return x + y;
            6'b010011: return x - y;
            6'b000111: return y - x;
            6'b000000: return x & y;
            6'b010101: return x | y;
            default:   return 'x;
        endcase
    endfunction

    task automatic emit(input hack_word_t word, input string tag);
        prog.push_back(word);
        prog_tag.push_back(tag);
    endtask

    task automatic build_program;
        int               k;
        int               j;
        int               s;
        int               target;
        logic [PC_W-1:0]  v;
        logic             pick_m;
        logic             pick_a;
        logic             pick_d;

        // each A value is stored to M at its own address
        for (k = 0; k < 4; k++)
        begin
            v = 15'($random(seed));
            emit(a_instr(v), "a_load");
            emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "a_load");
        end

        // D comes from a random M, then the function result lands in M
        // and the new D and A are stored afterwards to make them visible
        for (k = 0; k < 18; k++)
        begin
            pick_m = 1'($random(seed));
            pick_a = 1'($random(seed));
            pick_d = 1'($random(seed));
            emit(a_instr(15'($random(seed))), "alu_fn");
            emit(c_instr(1'b1, FN_Y, DST_D, JMP_NONE), "alu_fn");
            emit(a_instr(15'($random(seed))), "alu_fn");
            emit(c_instr(pick_m, ALU_CODES[k], {pick_a, pick_d, 1'b1}, JMP_NONE), "alu_fn");
            emit(c_instr(1'b0, FN_D, DST_M, JMP_NONE), "alu_fn");
            emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "alu_fn");
        end

        // A and M loaded by the same instruction, read and write use the old A
        emit(a_instr(15'($random(seed))), "old_a");
        emit(c_instr(1'b1, FN_Y_INC, DST_AM, JMP_NONE), "old_a");
        emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "old_a");
        emit(a_instr(15'($random(seed))), "old_a");
        emit(c_instr(1'b1, FN_Y_DEC, DST_AMD, JMP_NONE), "old_a");
        emit(c_instr(1'b0, FN_D, DST_M, JMP_NONE), "old_a");

        // every jump code against a negative, a zero and a positive D
        // a taken jump skips the first marker store
        for (j = 0; j < 5; j++)
        begin
            for (s = 0; s < 3; s++)
            begin
                v = (s == 1) ? '0 : (15'($random(seed)) | 15'd1);
                emit(a_instr(v), "jump");
                emit(c_instr(1'b0, FN_Y, DST_D, JMP_NONE), "jump");
                if (s == 0)
                    emit(c_instr(1'b0, FN_NEG_D, DST_D, JMP_NONE), "jump");
                target = prog.size() + 4;
                emit(a_instr(15'(target)), "jump");
                emit(c_instr(1'b0, FN_D, DST_NONE, JUMP_CODES[j]), "jump");
                emit(a_instr(15'($random(seed))), "jump");
                emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "jump");
                emit(a_instr(15'($random(seed))), "jump");
                emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "jump");
            end
        end

        // jump from an even pc to the odd half of the same word
        if (prog.size() % 2 == 0)
            emit(a_instr('0), "word_jump");
        emit(a_instr(15'(prog.size() + 2)), "word_jump");
        emit(c_instr(1'b0, FN_ZERO, DST_NONE, JMP_ALL), "word_jump");
        emit(a_instr(15'($random(seed))), "word_jump");
        emit(c_instr(1'b0, FN_Y, DST_M, JMP_NONE), "word_jump");

        // halt loop inside one even-aligned word, so it never reads the ROM again
        if (prog.size() % 2 != 0)
            emit(a_instr('0), "halt");
        halt_pc = prog.size();
        emit(a_instr(15'(halt_pc)), "halt");
        emit(c_instr(1'b0, FN_ZERO, DST_NONE, JMP_ALL), "halt");
    endtask

    // steps the instruction set over the program until the halt loop closes once
    task automatic ref_run;
        hack_word_t a;
        hack_word_t d;
        hack_word_t y;
        hack_word_t r;
        hack_word_t instr;
        pc_t        pc;
        pc_t        exec_pc;
        rom_addr_t  last_word;
        logic       fetched;
        logic       miss;
        logic       taken;
        int         e_cyc;
        ram_wr_t    w;

        a = '0;
        d = '0;
        pc = '0;
        last_word = '0;
        fetched = 1'b0;
        e_cyc = 0;
        n_steps = 0;
        while (n_steps < MAX_STEPS)
        begin
            // a ROM read only when the pc leaves the word fetched last
            miss = !fetched || pc[PC_W-1:1] != last_word;
            if (miss)
            begin
                exp_rom.push_back(pc[PC_W-1:1]);
                exp_rom_tag.push_back(prog_tag[pc]);
                exp_rom_cyc.push_back(e_cyc);
            end
            // the request cycle is the previous E cycle
            // a hit reaches its own E cycle two cycles later, a miss three
            e_cyc += miss ? 3 : 2;
            fetched = 1'b1;
            last_word = pc[PC_W-1:1];
            exec_pc = pc;
            instr = prog[pc];
            n_steps++;
            if (!instr[BIT_C])
            begin
                a = {1'b0, instr[PC_W-1:0]};
                pc = pc + pc_t'(1);
            end
            else
            begin
                y = instr[BIT_AM] ? ram_ref[a[RAM_ADDR_W-1:0]] : a;
                r = expected_alu(instr[ALU_FN_LSB +: ALU_FN_W], d, y);
                if (instr[BIT_LD_M])
                begin
                    ram_ref[a[RAM_ADDR_W-1:0]] = r;
                    w.en = 1'b1;
                    w.addr = a[RAM_ADDR_W-1:0];
                    w.data = r;
                    exp_wr.push_back(w);
                    exp_wr_tag.push_back(prog_tag[pc]);
                end
                taken = (instr[BIT_JLT] && r[DATA_W-1]) || (instr[BIT_JEQ] && r == '0) ||
                        (instr[BIT_JGT] && !r[DATA_W-1] && r != '0);
                pc = taken ? a[PC_W-1:0] : pc + pc_t'(1);
                if (instr[BIT_LD_A])
                    a = r;
                if (instr[BIT_LD_D])
                    d = r;
            end
            if (exec_pc == pc_t'(halt_pc + 1))
                break;
        end
    endtask

    // ************************************************************
    // checks
    // ************************************************************

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_write(input string name, input ram_wr_t expected, input ram_wr_t actual);
        if (expected !== actual)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "RAM write differs from the reference");
        end
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t expected,
                                  input rom_addr_t actual);
        if (expected !== actual)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "ROM address differs from the reference");
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("Fail %s expected cycle %0d actual cycle %0d", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "ROM read at a different cycle than the reference");
        end
    endtask

    // outputs are sampled half a cycle after the edge that set them
    // a read shows up as a new ROM address, apart from the first one after reset
    // its cycle also shows whether a buffered word was read again in between
    always @(negedge clk)
    begin
        if (!resetN)
        begin
            first_fetch = 1'b1;
            cycle_count = 0;
            if (ram_wr.en)
                report_failure("RAM write enable was high during reset");
        end
        else
        begin
            if (first_fetch || inst_addr != last_rom_addr)
            begin
                if (exp_rom.size() == 0)
                    report_failure("ROM read after the reference program had ended");
                else
                begin
                    check_rom_addr(exp_rom_tag[0], exp_rom.pop_front(), inst_addr);
                    check_cycle(exp_rom_tag.pop_front(), exp_rom_cyc.pop_front(), cycle_count);
                end
            end
            first_fetch = 1'b0;
            last_rom_addr = inst_addr;
            if (ram_wr.en)
            begin
                if (exp_wr.size() == 0)
                    report_failure("RAM write that the reference program never makes");
                else
                    check_write(exp_wr_tag.pop_front(), exp_wr.pop_front(), ram_wr);
            end
            cycle_count++;
        end
    end

    // ************************************************************
    // main sequence and watchdog
    // ************************************************************

    initial
    begin
        int k;

        resetN = 1'b0;
        seed = 4;
        // unused ROM holds harmless A-instructions tied to their word address
        for (k = 0; k < (1 << ROM_ADDR_W); k++)
            rom[k] = {2'b01, 14'(k), 2'b00, 14'(k)};
        for (k = 0; k < (1 << RAM_ADDR_W); k++)
        begin
            ram[k] = ram_fill(k);
            ram_ref[k] = ram[k];
        end
        build_program();
        for (k = 0; k < prog.size() / 2; k++)
            rom[k] = {prog[2*k+1], prog[2*k]};
        ref_run();
        ref_ready = 1'b1;

        repeat (4) @(posedge clk);
        resetN <= 1'b1;

        // missing writes or ROM reads leave this loop to the watchdog
        while (exp_wr.size() != 0 || exp_rom.size() != 0)
            @(negedge clk);
        // the core now spins in the halt loop, which must stay silent
        repeat (10) @(negedge clk);

        $display("*** PASSED ***");
        $finish;
    end

    // no instruction takes more than 4 cycles, the margin covers reset and the tail
    initial
    begin
        wait (ref_ready);
        #(n_steps * 4 * CLK_PERIOD + 200);
        $display("timeout with %0d writes and %0d ROM reads still missing",
                 exp_wr.size(), exp_rom.size());
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
